// ==== include/iq_settings.svh ====
// iq order settings
// sizing macros for the in-order retirement queue
// shared by the package, the rtl blocks and the checker

`ifndef IQ_SETTINGS_SVH
`define IQ_SETTINGS_SVH

// ==============================
// queue geometry
// ==============================

// number of issue-queue slots in the ring
// kept a power of two so slot arithmetic wraps for free
`define IQ_ENTRIES 8

// retire lanes per cycle
`define COMMIT_WIDTH 2

// ==============================
// field widths
// ==============================

// opaque instruction payload carried through to retire
`define PAYLOAD_BITS 16

// sequence number width
// live numbers run 1..IQ_ENTRIES, so one bit wider than a slot index
`define SN_BITS 4

`endif

// ==== design/iq_pkg.sv ====
// iq order package
// slot, sequence number, payload and retire count types
// plus the record that dispatch hands to the entry store

`include "iq_settings.svh"

package iq_pkg;

	// ==============================
	// derived sizes
	// ==============================

	// slot index width, 3 bits for 8 entries
	localparam int QBITS = $clog2(`IQ_ENTRIES);

	// retire count must hold 0..COMMIT_WIDTH
	localparam int AMT_BITS = $clog2(`COMMIT_WIDTH + 1);

	// ==============================
	// scalar types
	// ==============================

	// index into the entry ring
	typedef logic [QBITS-1:0] slot_t;

	// program order rank, 1 is oldest, 0 means no entry
	typedef logic [`SN_BITS-1:0] sn_t;

	// instruction payload
	typedef logic [`PAYLOAD_BITS-1:0] payload_t;

	// entries retiring in one cycle
	typedef logic [AMT_BITS-1:0] amt_t;

	// ==============================
	// dispatch record
	// ==============================

	// one new entry as written by dispatch
	// slot is the ring tail, sn is the next rank after renormalizing
	typedef struct packed {
		slot_t    slot;
		sn_t      sn;
		payload_t payload;
	} disp_rec_t;

endpackage

// ==== design/iq_state_if.sv ====
// iq state interface
// queue state and retire request shared by store, sequencing,
// dispatch and commit

`timescale 1ns/10ps
`include "iq_settings.svh"

interface iq_state_if (
	input logic clk,
	input logic rst_n
);
	// entry state, registered in the store
	logic [`IQ_ENTRIES-1:0] iq_v;
	logic [`IQ_ENTRIES-1:0] iq_done;
	iq_pkg::sn_t            iq_sn [`IQ_ENTRIES];
	iq_pkg::payload_t       iq_payload [`IQ_ENTRIES];

	// heads[j] is the slot of the j-th oldest entry
	iq_pkg::slot_t          heads [`IQ_ENTRIES];

	// entries retiring this cycle, from commit
	iq_pkg::amt_t           hi_amt;

	// sequencing results
	iq_pkg::sn_t            maxsn;
	iq_pkg::sn_t            tosub;

	// new entry from dispatch
	logic                   wr_en;
	iq_pkg::disp_rec_t      wr_rec;

	modport store (output iq_v, iq_done, iq_sn, iq_payload, heads,
		input hi_amt, maxsn, tosub, wr_en, wr_rec);

	// clk and rst_n only feed the checks in the sequencing block
	modport seq (input clk, rst_n, iq_v, iq_sn, heads, hi_amt,
		output maxsn, tosub);

	modport dispatch (input iq_v, maxsn, tosub, output wr_en, wr_rec);

	modport commit (input iq_v, iq_done, iq_sn, iq_payload, heads,
		output hi_amt);

endinterface

// ==== design/iq_dispatch.sv ====
// iq dispatch
// input side of the queue: valid/ready handshake on new instructions,
// tail slot selection and sequence number assignment

`timescale 1ns/10ps
`include "iq_settings.svh"

module iq_dispatch (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  iq_pkg::payload_t in_payload,
	output logic             in_ready,
	iq_state_if.dispatch     st
);

	// next free slot in program order
	iq_pkg::slot_t tail_q;

	// every slot holds a live entry
	logic full;

	// handshake this cycle
	logic xfer;

	// ==============================
	// handshake
	// ==============================

	// ready depends only on registered valid bits
	// a retire in the same cycle does not open a slot early
	assign full = &st.iq_v;
	assign in_ready = !full;
	assign xfer = in_valid && in_ready;

	// store takes the record at the edge of the handshake
	assign st.wr_en = xfer;

	// ==============================
	// record build
	// ==============================

	// survivors drop by tosub this edge, so the new entry lands
	// one above the renormalized maximum
	always_comb
	begin
		st.wr_rec.slot = tail_q;
		st.wr_rec.sn = st.maxsn - st.tosub + iq_pkg::sn_t'(1);
		st.wr_rec.payload = in_payload;
	end

	// tail walks the ring, wraps at IQ_ENTRIES
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tail_q <= '0;
		else if (xfer)
			tail_q <= tail_q + iq_pkg::slot_t'(1);
	end

	// ==============================
	// checks
	// ==============================

	// tail must stay ahead of the store's head pointer
	// a live slot under the tail means the ring pointers drifted apart
	a_wr_free_slot: assert property (
		@(posedge clk) disable iff (!rst_n)
		st.wr_en |-> !st.iq_v[st.wr_rec.slot]
	);

endmodule

// ==== design/iq_seqnum.sv ====
// iq sequence numbers
// finds the largest live sequence number and the amount every
// survivor drops by when the oldest entries retire

`timescale 1ns/10ps
`include "iq_settings.svh"

module iq_seqnum (
	iq_state_if.seq st
);

	iq_pkg::sn_t maxsn_c;
	iq_pkg::sn_t tosub_c;

	// ==============================
	// maximum live rank
	// ==============================

	// invalid entries hold zero, the valid term keeps it robust anyway
	always_comb
	begin
		maxsn_c = '0;
		for (int n = 0; n < `IQ_ENTRIES; n++)
		begin
			if (st.iq_v[n] && (st.iq_sn[n] > maxsn_c))
				maxsn_c = st.iq_sn[n];
		end
	end

	// ==============================
	// retire subtraction
	// ==============================

	// last live entry among the first hi_amt heads
	// hi_amt never exceeds COMMIT_WIDTH so the walk stops there
	always_comb
	begin
		tosub_c = '0;
		for (int j = 0; j < `COMMIT_WIDTH; j++)
		begin
			if ((j < int'(st.hi_amt)) && st.iq_v[st.heads[j]])
				tosub_c = st.iq_sn[st.heads[j]];
		end
	end

	assign st.maxsn = maxsn_c;
	assign st.tosub = tosub_c;

	// cannot remove more ranks than are live
	a_tosub_le_max: assert property (
		@(posedge st.clk) disable iff (!st.rst_n)
		st.tosub <= st.maxsn
	);

	// heads carry ranks 1..hi_amt, so the drop equals the lane count
	a_tosub_is_amt: assert property (
		@(posedge st.clk) disable iff (!st.rst_n)
		st.tosub == iq_pkg::sn_t'(st.hi_amt)
	);

endmodule

// ==== design/iq_store.sv ====
// iq entry store
// ring of entries with valid, done, sequence number and payload;
// applies dispatch writes, completions, retirement and renormalization

`timescale 1ns/10ps
`include "iq_settings.svh"

module iq_store (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          cpl_valid,
	input  iq_pkg::slot_t cpl_slot,
	output iq_pkg::sn_t   occupancy,
	iq_state_if.store     st
);

	// entry state
	logic [`IQ_ENTRIES-1:0] v_q;
	logic [`IQ_ENTRIES-1:0] done_q;
	iq_pkg::sn_t            sn_q [`IQ_ENTRIES];
	iq_pkg::payload_t       pay_q [`IQ_ENTRIES];

	// oldest slot in the ring
	iq_pkg::slot_t          head_q;

	// heads in age order and the slots leaving this edge
	iq_pkg::slot_t          head_slot [`IQ_ENTRIES];
	logic [`IQ_ENTRIES-1:0] retire;

	// ==============================
	// age order
	// ==============================

	// j-th oldest sits j slots past the head, wrap is implicit
	always_comb
	begin
		for (int j = 0; j < `IQ_ENTRIES; j++)
			head_slot[j] = head_q + iq_pkg::slot_t'(j);
	end

	// commit retires a prefix of the heads
	always_comb
	begin
		retire = '0;
		for (int j = 0; j < `COMMIT_WIDTH; j++)
		begin
			if (j < int'(st.hi_amt))
				retire[head_slot[j]] = 1'b1;
		end
	end

	// ==============================
	// entry update
	// ==============================

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			v_q <= '0;
			done_q <= '0;
			head_q <= '0;
			for (int i = 0; i < `IQ_ENTRIES; i++)
				sn_q[i] <= '0;
		end
		else
		begin
			head_q <= head_q + iq_pkg::slot_t'(st.hi_amt);
			for (int i = 0; i < `IQ_ENTRIES; i++)
			begin
				// retired slot goes back to zero rank
				if (retire[i])
				begin
					v_q[i] <= 1'b0;
					done_q[i] <= 1'b0;
					sn_q[i] <= '0;
				end
				// survivors renormalize so ranks stay 1..occupancy
				else if (v_q[i])
					sn_q[i] <= sn_q[i] - st.tosub;
			end
			// completion lands on a live, non-retiring slot
			if (cpl_valid)
				done_q[cpl_slot] <= 1'b1;
			// tail slot is free, so no clash with the above
			if (st.wr_en)
			begin
				v_q[st.wr_rec.slot] <= 1'b1;
				done_q[st.wr_rec.slot] <= 1'b0;
				sn_q[st.wr_rec.slot] <= st.wr_rec.sn;
			end
		end
	end

	// payload only changes on a write
	always_ff @(posedge clk)
	begin
		if (st.wr_en)
			pay_q[st.wr_rec.slot] <= st.wr_rec.payload;
	end

	// ==============================
	// outputs
	// ==============================

	assign st.iq_v = v_q;
	assign st.iq_done = done_q;
	assign st.iq_sn = sn_q;
	assign st.iq_payload = pay_q;
	assign st.heads = head_slot;

	// highest rank equals entry count
	assign occupancy = st.maxsn;

	// completion of a free slot would later retire garbage
	a_cpl_live: assert property (
		@(posedge clk) disable iff (!rst_n)
		cpl_valid |-> v_q[cpl_slot]
	);

	// rank invariant against an independent count of live slots
	a_occ_count: assert property (
		@(posedge clk) disable iff (!rst_n)
		$countones(v_q) == int'(occupancy)
	);

endmodule

// ==== design/iq_commit.sv ====
// iq commit
// output side of the queue: presents up to COMMIT_WIDTH oldest done
// entries in order and retires all valid lanes on out_ready

`timescale 1ns/10ps
`include "iq_settings.svh"

module iq_commit (
	input  logic                     out_ready,
	output logic [`COMMIT_WIDTH-1:0] out_valid,
	output iq_pkg::sn_t              out_sn [`COMMIT_WIDTH],
	output iq_pkg::payload_t         out_payload [`COMMIT_WIDTH],
	iq_state_if.commit               st
);

	// head j is live and done
	logic [`COMMIT_WIDTH-1:0] lane_ok;

	// lane j valid, needs every older lane too
	logic [`COMMIT_WIDTH-1:0] lane_v;

	// number of valid lanes
	iq_pkg::amt_t             lane_cnt;

	// ==============================
	// lane formation
	// ==============================

	always_comb
	begin
		for (int j = 0; j < `COMMIT_WIDTH; j++)
			lane_ok[j] = st.iq_v[st.heads[j]] && st.iq_done[st.heads[j]];
	end

	// strict in-order: a younger done entry waits behind an older one
	always_comb
	begin
		lane_v[0] = lane_ok[0];
		for (int j = 1; j < `COMMIT_WIDTH; j++)
			lane_v[j] = lane_v[j-1] && lane_ok[j];
	end

	// lanes form a prefix, so counting set bits gives the depth
	always_comb
	begin
		lane_cnt = '0;
		for (int j = 0; j < `COMMIT_WIDTH; j++)
		begin
			if (lane_v[j])
				lane_cnt = lane_cnt + iq_pkg::amt_t'(1);
		end
	end

	// ==============================
	// retire channel
	// ==============================

	assign out_valid = lane_v;

	// data follows the heads whether or not the lane is valid
	// lane j rank is j+1 by the renormalization invariant
	always_comb
	begin
		for (int j = 0; j < `COMMIT_WIDTH; j++)
		begin
			out_sn[j] = st.iq_sn[st.heads[j]];
			out_payload[j] = st.iq_payload[st.heads[j]];
		end
	end

	// back-pressure holds every lane, nothing leaves
	assign st.hi_amt = out_ready ? lane_cnt : '0;

endmodule

// ==== design/iq_order_top.sv ====
// iq order top
// in-order retirement queue: dispatch in program order, complete in
// any order, retire oldest first up to COMMIT_WIDTH per cycle

`timescale 1ns/10ps
`include "iq_settings.svh"

module iq_order_top (
	input  logic                     clk,
	input  logic                     rst_n,
	// dispatch channel
	input  logic                     in_valid,
	output logic                     in_ready,
	input  iq_pkg::payload_t         in_payload,
	// completion by slot
	input  logic                     cpl_valid,
	input  iq_pkg::slot_t            cpl_slot,
	// retire channel
	output logic [`COMMIT_WIDTH-1:0] out_valid,
	input  logic                     out_ready,
	output iq_pkg::sn_t              out_sn [`COMMIT_WIDTH],
	output iq_pkg::payload_t         out_payload [`COMMIT_WIDTH],
	// live entry count
	output iq_pkg::sn_t              occupancy
);

	// ==============================
	// shared queue state
	// ==============================

	iq_state_if st (
		.clk   (clk),
		.rst_n (rst_n)
	);

	iq_dispatch i_dispatch (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_payload (in_payload),
		.in_ready   (in_ready),
		.st         (st.dispatch)
	);

	// purely combinational rank logic
	iq_seqnum i_seqnum (
		.st (st.seq)
	);

	iq_store i_store (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpl_valid (cpl_valid),
		.cpl_slot  (cpl_slot),
		.occupancy (occupancy),
		.st        (st.store)
	);

	iq_commit i_commit (
		.out_ready   (out_ready),
		.out_valid   (out_valid),
		.out_sn      (out_sn),
		.out_payload (out_payload),
		.st          (st.commit)
	);

endmodule

// ==== test/iq_order_checker.sv ====
// iq order checker
// reference model of program order, completion and occupancy for the
// retirement queue; compares the retire channel and reports per test

`timescale 1ns/10ps
`include "iq_settings.svh"

module iq_order_checker (
	input logic                     clk,
	input logic                     rst_n,
	input logic                     in_valid,
	input logic                     in_ready,
	input iq_pkg::payload_t         in_payload,
	input logic                     cpl_valid,
	input iq_pkg::slot_t            cpl_slot,
	input logic [`COMMIT_WIDTH-1:0] out_valid,
	input logic                     out_ready,
	input iq_pkg::sn_t              out_sn [`COMMIT_WIDTH],
	input iq_pkg::payload_t         out_payload [`COMMIT_WIDTH],
	input iq_pkg::sn_t              occupancy
);

	// live entries in age order, oldest at the front
	iq_pkg::payload_t q_pay [$];
	iq_pkg::slot_t    q_slot [$];
	logic             q_done [$];

	// ring tail as the model sees it
	iq_pkg::slot_t    tail;

	// last cycle's view for the back-pressure rule
	int               prev_occ;
	logic             prev_ready;

	// per test and overall counts
	string cur_name = "reset";
	int n_tests = 0;
	int t_checks = 0;
	int t_errs = 0;
	int total_checks = 0;
	int err_cnt = 0;

	// ==============================
	// reporting
	// ==============================

	task automatic begin_test(input string name);
		cur_name = name;
		t_checks = 0;
		t_errs = 0;
	endtask

	task automatic end_test();
		n_tests++;
		$display("test %s: %0d checks, %0d mismatches", cur_name, t_checks, t_errs);
	endtask

	task automatic check_value(input string what, input int exp, input int act);
		t_checks++;
		total_checks++;
		if (exp != act)
		begin
			t_errs++;
			err_cnt++;
			$display("ERROR %s: %s expected %0d actual %0d", cur_name, what, exp, act);
		end
	endtask

	task automatic report_failure(input string msg);
		t_errs++;
		err_cnt++;
		$display("ERROR %s: %s", cur_name, msg);
	endtask

	// ==============================
	// model and compare
	// ==============================

	// negedge sees the inputs that the next rising edge acts on
	always @(negedge clk)
	begin
		logic exp_v;
		int   n_ret;
		if (!rst_n)
		begin
			q_pay.delete();
			q_slot.delete();
			q_done.delete();
			tail = '0;
			prev_occ = 0;
			prev_ready = 1'b1;
		end
		else
		begin
			check_value("occupancy", q_pay.size(), occupancy);
			check_value("in_ready", q_pay.size() != `IQ_ENTRIES, in_ready);
			if (!prev_ready && (int'(occupancy) < prev_occ))
				report_failure("occupancy fell while out_ready was low");
			// lanes are a prefix of done entries from the oldest
			exp_v = 1'b1;
			n_ret = 0;
			for (int j = 0; j < `COMMIT_WIDTH; j++)
			begin
				exp_v = exp_v && (q_pay.size() > j) && q_done[j];
				check_value($sformatf("out_valid[%0d]", j), exp_v, out_valid[j]);
				if (exp_v)
				begin
					n_ret++;
					// rank j+1 after renormalizing
					check_value($sformatf("out_sn[%0d]", j), j + 1, out_sn[j]);
					check_value($sformatf("out_payload[%0d]", j), q_pay[j], out_payload[j]);
				end
			end
			prev_occ = int'(occupancy);
			prev_ready = out_ready;
			if (out_ready)
			begin
				repeat (n_ret)
				begin
					void'(q_pay.pop_front());
					void'(q_slot.pop_front());
					void'(q_done.pop_front());
				end
			end
			// completion marks the live entry in that slot
			if (cpl_valid)
			begin
				foreach (q_slot[i])
				begin
					if (q_slot[i] == cpl_slot)
						q_done[i] = 1'b1;
				end
			end
			if (in_valid && in_ready)
			begin
				q_pay.push_back(in_payload);
				q_slot.push_back(tail);
				q_done.push_back(1'b0);
				tail = tail + iq_pkg::slot_t'(1);
			end
		end
	end

endmodule

// ==== test/tb_iq_order.sv ====
// iq order testbench
// drives the retirement queue through a table of dispatch counts,
// completion orders and back-pressure patterns

`timescale 1ns/10ps
`include "iq_settings.svh"

module tb_iq_order;

	localparam int NUM_TESTS = 7;
	localparam int RESET_CYCLES = 5;

	// ==============================
	// stimulus table
	// ==============================

	// order: 0 oldest first, 1 youngest first, 2 scrambled
	// ready: one bit per cycle, rotating; zero means scrambled gaps
	string      tbl_name [NUM_TESTS] = '{"single", "in_order", "reverse",
		"alt_ready", "backpressure", "fill", "scramble"};
	int         tbl_count [NUM_TESTS] = '{1, 6, 8, 8, 8, 14, 20};
	int         tbl_order [NUM_TESTS] = '{0, 0, 1, 0, 2, 2, 2};
	logic [7:0] tbl_ready [NUM_TESTS] = '{8'hff, 8'hff, 8'hff, 8'haa, 8'h11,
		8'h00, 8'h00};

	logic                     clk;
	logic                     rst_n;
	logic                     in_valid;
	logic                     in_ready;
	iq_pkg::payload_t         in_payload;
	logic                     cpl_valid;
	iq_pkg::slot_t            cpl_slot;
	logic [`COMMIT_WIDTH-1:0] out_valid;
	logic                     out_ready;
	iq_pkg::sn_t              out_sn [`COMMIT_WIDTH];
	iq_pkg::payload_t         out_payload [`COMMIT_WIDTH];
	iq_pkg::sn_t              occupancy;

	// stimulus state
	logic [31:0]              rng;
	iq_pkg::slot_t            tail;
	iq_pkg::payload_t         pay_next;
	int                       cycle_cnt = 0;

	iq_order_top i_iq_order_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_payload  (in_payload),
		.cpl_valid   (cpl_valid),
		.cpl_slot    (cpl_slot),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.out_sn      (out_sn),
		.out_payload (out_payload),
		.occupancy   (occupancy)
	);

	iq_order_checker i_checker (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] r;
		r = x ^ (x << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	// which pending entry completes next
	function automatic int pick_index(input int order, input int size, input logic [31:0] r);
		if (order == 0)
			return 0;
		else if (order == 1)
			return size - 1;
		else
			return int'(r[15:0]) % size;
	endfunction

	// eight cycles per dispatched instruction plus reset
	function automatic int timeout_limit();
		int sum;
		sum = 0;
		for (int i = 0; i < NUM_TESTS; i++)
			sum += tbl_count[i];
		return RESET_CYCLES + 8 * sum;
	endfunction

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_limit())
		begin
			$display("timeout: run did not finish within %0d cycles", timeout_limit());
			$display("Errors found");
			$finish;
		end
	end

	// ==============================
	// one table row
	// ==============================

	// completions start once dispatch has stalled or ended,
	// so the fill rows really reach a full queue
	task automatic run_test(input int t);
		iq_pkg::slot_t pend [$];
		int            n_disp;
		int            n_cpl;
		int            cyc;
		int            k;
		logic          go;
		logic          take;
		n_disp = 0;
		n_cpl = 0;
		cyc = 0;
		go = 1'b0;
		i_checker.begin_test(tbl_name[t]);
		while (n_cpl < tbl_count[t])
		begin
			rng = xorshift(rng);
			in_valid = (n_disp < tbl_count[t]);
			in_payload = pay_next;
			if (tbl_ready[t] == 8'h00)
				out_ready = rng[8];
			else
				out_ready = tbl_ready[t][cyc % 8];
			cpl_valid = 1'b0;
			if (go && (pend.size() > 0))
			begin
				k = pick_index(tbl_order[t], pend.size(), rng);
				cpl_valid = 1'b1;
				cpl_slot = pend[k];
				pend.delete(k);
				n_cpl++;
			end
			@(negedge clk);
			take = in_valid && in_ready;
			go = go || !take;
			@(posedge clk);
			#2;
			// accepted entry is live now, ring tail moves on
			if (take)
			begin
				pend.push_back(tail);
				tail = tail + iq_pkg::slot_t'(1);
				pay_next = pay_next + iq_pkg::payload_t'(1);
				n_disp++;
			end
			cyc++;
		end
		// drain with the retire channel open
		cpl_valid = 1'b0;
		in_valid = 1'b0;
		out_ready = 1'b1;
		do
			@(negedge clk);
		while (occupancy != '0);
		@(posedge clk);
		#2;
		i_checker.end_test();
	endtask

	initial
	begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_payload = '0;
		cpl_valid = 1'b0;
		cpl_slot = '0;
		out_ready = 1'b0;
		rng = 32'd31;
		tail = '0;
		pay_next = 16'h0100;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		repeat (2) @(posedge clk);
		$display("%0d tests, %0d checks, %0d mismatches", i_checker.n_tests,
			i_checker.total_checks, i_checker.err_cnt);
		if (i_checker.err_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+include
design/iq_pkg.sv
design/iq_state_if.sv
design/iq_dispatch.sv
design/iq_seqnum.sv
design/iq_store.sv
design/iq_commit.sv
design/iq_order_top.sv
test/iq_order_checker.sv
test/tb_iq_order.sv

// ==== Bender.yml ====
package:
  name: iq_order

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/iq_pkg.sv
      - design/iq_state_if.sv
      - design/iq_dispatch.sv
      - design/iq_seqnum.sv
      - design/iq_store.sv
      - design/iq_commit.sv
      - design/iq_order_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/iq_order_checker.sv
      - test/tb_iq_order.sv
